//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_two_read_mem
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- project.f
src/mrpw_pkg.sv
src/init_sequencer.sv
src/bank_scheduler.sv
src/parity_updater.sv
src/read_assembler.sv
src/two_read_mem.sv
test/sram_model.sv
test/two_read_mem_checker.sv
test/tb_two_read_mem.sv

//--- src/bank_scheduler.sv
`default_nettype none

module bank_scheduler (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ready,
  input  logic                       init_active,
  input  logic [mrpw_pkg::ROW_W-1:0] init_row,
  input  mrpw_pkg::rd_req_t          rd_req [mrpw_pkg::NUM_RD_PORTS],
  input  mrpw_pkg::wr_req_t          wr_req,
  output mrpw_pkg::bank_cmd_t        bank_cmd [mrpw_pkg::NUM_BANKS],
  output mrpw_pkg::rd_req_t          conflict_rd,
  output mrpw_pkg::rd_pipe_t         rd_pipe [mrpw_pkg::NUM_RD_PORTS]
);

  logic                    wr_vld;
  logic                    rd_go [mrpw_pkg::NUM_RD_PORTS];
  logic                    conflict;
  mrpw_pkg::rd_pipe_t      pipe [mrpw_pkg::NUM_RD_PORTS][mrpw_pkg::SRAM_DELAY];

  always_comb begin
    wr_vld = wr_req.valid && ready;
    for (int p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin
      rd_go[p] = rd_req[p].valid && ready && !wr_vld;
    end
    conflict          = rd_go[0] && rd_go[1] && (rd_req[0].bank == rd_req[1].bank);
    conflict_rd.valid = conflict;
    conflict_rd.bank  = rd_req[1].bank;
    conflict_rd.row   = rd_req[1].row;
  end

  always_comb begin
    for (int b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin
      bank_cmd[b] = '0;
      if (init_active) begin
        bank_cmd[b].write = 1'b1; // zero every row
        bank_cmd[b].row   = init_row;
      end else if (wr_vld) begin
        bank_cmd[b].row = wr_req.row;
        if (mrpw_pkg::BANK_W'(b) == wr_req.bank) begin
          bank_cmd[b].write = 1'b1;
          bank_cmd[b].data  = wr_req.data;
        end else begin
          bank_cmd[b].read = 1'b1; // old words of the row feed the new parity
        end
      end else begin
        if (rd_go[0] && rd_req[0].bank == mrpw_pkg::BANK_W'(b)) begin
          bank_cmd[b].read = 1'b1;
          bank_cmd[b].row  = rd_req[0].row;
        end
        if (rd_go[1] && (conflict ? rd_req[1].bank != mrpw_pkg::BANK_W'(b)
                                  : rd_req[1].bank == mrpw_pkg::BANK_W'(b))) begin
          bank_cmd[b].read = 1'b1;
          bank_cmd[b].row  = rd_req[1].row;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin
      pipe[p][0].req         <= rd_req[p];
      pipe[p][0].req.valid   <= rd_go[p];
      pipe[p][0].rebuild     <= (p == 1) && conflict;
      for (int k = 1; k < mrpw_pkg::SRAM_DELAY; k++) begin
        pipe[p][k] <= pipe[p][k-1];
      end
      if (rst) begin
        for (int k = 0; k < mrpw_pkg::SRAM_DELAY; k++) begin
          pipe[p][k].req.valid <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin
      rd_pipe[p] = pipe[p][mrpw_pkg::SRAM_DELAY-1];
    end
  end

endmodule

`default_nettype wire

//--- src/init_sequencer.sv
`default_nettype none

module init_sequencer (
  input  logic                       clk,
  input  logic                       rst,
  output logic                       init_active,
  output logic [mrpw_pkg::ROW_W-1:0] init_row,
  output logic                       ready
);

  logic [mrpw_pkg::ROW_W:0]      row_cnt;
  logic [mrpw_pkg::ROW_W:0]      row_nxt;
  logic [mrpw_pkg::SRAM_DELAY:0] done_dly;

  assign row_nxt  = row_cnt + (mrpw_pkg::ROW_W + 1)'(init_active);
  assign init_row = row_cnt[mrpw_pkg::ROW_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      row_cnt     <= '0;
      init_active <= 1'b0;
      done_dly    <= '0;
      ready       <= 1'b0;
    end else begin
      row_cnt     <= row_nxt;
      init_active <= (row_nxt != mrpw_pkg::NUM_ROWS); // stops right after the last row
      // the last zero parity still has to leave the queue before ready
      done_dly    <= {done_dly[mrpw_pkg::SRAM_DELAY-1:0], row_cnt == mrpw_pkg::NUM_ROWS};
      ready       <= done_dly[mrpw_pkg::SRAM_DELAY];
    end
  end

endmodule

`default_nettype wire

//--- src/mrpw_pkg.sv
`default_nettype none

package mrpw_pkg;

  localparam int DATA_W       = 16;
  localparam int NUM_BANKS    = 8;
  localparam int BANK_W       = 3;
  localparam int NUM_ROWS     = 64;
  localparam int ROW_W        = 6;
  localparam int ADDR_W       = BANK_W + ROW_W; // bank in the low bits, row above it
  localparam int NUM_RD_PORTS = 2;
  localparam int SRAM_DELAY   = 2;
  localparam int PQ_DEPTH     = SRAM_DELAY + 1;
  localparam int PQ_CNT_W     = $clog2(PQ_DEPTH + 1);

  typedef logic [DATA_W-1:0] data_t;

  typedef struct packed {
    logic              valid;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
  } rd_req_t;

  typedef struct packed {
    logic              valid;
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    data_t             data;
  } wr_req_t;

  typedef struct packed {
    logic  valid;
    data_t data;
  } rd_rsp_t;

  typedef struct packed {
    rd_req_t req;
    logic    rebuild; // word is rebuilt from the other banks and parity
  } rd_pipe_t;

  typedef struct packed {
    logic             write;
    logic             read;
    logic [ROW_W-1:0] row;
    data_t            data;
  } bank_cmd_t;

endpackage

`default_nettype wire

//--- src/parity_updater.sv
`default_nettype none

module parity_updater (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ready,
  input  logic                       init_active,
  input  logic [mrpw_pkg::ROW_W-1:0] init_row,
  input  mrpw_pkg::wr_req_t          wr_req,
  input  mrpw_pkg::rd_req_t          conflict_rd,
  input  mrpw_pkg::data_t            bank_rdata [mrpw_pkg::NUM_BANKS],
  input  mrpw_pkg::data_t            parity_rdata,
  output mrpw_pkg::bank_cmd_t        parity_cmd,
  output mrpw_pkg::data_t            parity_word
);

  mrpw_pkg::wr_req_t             wr_in;
  mrpw_pkg::wr_req_t             wr_pipe [mrpw_pkg::SRAM_DELAY];
  mrpw_pkg::wr_req_t             wr_out;
  mrpw_pkg::data_t               new_parity;
  logic                          push_vld;
  logic [mrpw_pkg::ROW_W-1:0]    push_row;
  mrpw_pkg::data_t               push_data;
  logic                          drain_slot;
  logic                          pop;
  logic [mrpw_pkg::PQ_CNT_W-1:0] pq_cnt;
  logic [mrpw_pkg::PQ_CNT_W-1:0] wr_slot;
  logic [mrpw_pkg::ROW_W-1:0]    pq_row [mrpw_pkg::PQ_DEPTH];
  mrpw_pkg::data_t               pq_data [mrpw_pkg::PQ_DEPTH];
  logic                          srch_hit;
  mrpw_pkg::data_t               srch_data;
  logic [mrpw_pkg::ROW_W-1:0]    fwd_row [mrpw_pkg::SRAM_DELAY];
  logic                          fwd_hit [mrpw_pkg::SRAM_DELAY];
  mrpw_pkg::data_t               fwd_data [mrpw_pkg::SRAM_DELAY];

  always_comb begin
    wr_in       = wr_req;
    wr_in.valid = wr_req.valid && ready;
    wr_out      = wr_pipe[mrpw_pkg::SRAM_DELAY-1];
    new_parity  = wr_out.data; // the written bank did not read, so use the new word
    for (int b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin
      if (mrpw_pkg::BANK_W'(b) != wr_out.bank) begin
        new_parity = new_parity ^ bank_rdata[b];
      end
    end
    push_vld   = init_active || wr_out.valid;
    push_row   = init_active ? init_row : wr_out.row;
    push_data  = init_active ? '0 : new_parity;
    drain_slot = !ready || wr_in.valid; // the parity bank is free of reads only then
    pop        = drain_slot && (pq_cnt != '0);
    wr_slot    = pq_cnt - mrpw_pkg::PQ_CNT_W'(pop);
  end

  always_ff @(posedge clk) begin
    wr_pipe[0] <= wr_in;
    for (int k = 1; k < mrpw_pkg::SRAM_DELAY; k++) begin
      wr_pipe[k] <= wr_pipe[k-1];
    end
    if (rst) begin
      for (int k = 0; k < mrpw_pkg::SRAM_DELAY; k++) begin
        wr_pipe[k].valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pq_cnt <= '0;
    end else begin
      pq_cnt <= pq_cnt + mrpw_pkg::PQ_CNT_W'(push_vld) - mrpw_pkg::PQ_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < mrpw_pkg::PQ_DEPTH; i++) begin
      if (push_vld && wr_slot == mrpw_pkg::PQ_CNT_W'(i)) begin
        pq_row[i]  <= push_row;
        pq_data[i] <= push_data;
      end else if (pop && i < mrpw_pkg::PQ_DEPTH - 1) begin
        pq_row[i]  <= pq_row[i+1];
        pq_data[i] <= pq_data[i+1];
      end
    end
  end

  // newest match wins, and this cycle's push is newer than anything queued
  always_comb begin
    srch_hit  = 1'b0;
    srch_data = '0;
    for (int i = 0; i < mrpw_pkg::PQ_DEPTH; i++) begin
      if (mrpw_pkg::PQ_CNT_W'(i) < pq_cnt && pq_row[i] == conflict_rd.row) begin
        srch_hit  = 1'b1;
        srch_data = pq_data[i];
      end
    end
    if (push_vld && push_row == conflict_rd.row) begin
      srch_hit  = 1'b1;
      srch_data = push_data;
    end
  end

  always_ff @(posedge clk) begin
    fwd_row[0]  <= conflict_rd.row;
    fwd_hit[0]  <= srch_hit;
    fwd_data[0] <= srch_data;
    for (int k = 1; k < mrpw_pkg::SRAM_DELAY; k++) begin
      fwd_row[k] <= fwd_row[k-1];
      if (push_vld && push_row == fwd_row[k-1]) begin
        fwd_hit[k]  <= 1'b1;
        fwd_data[k] <= push_data;
      end else begin
        fwd_hit[k]  <= fwd_hit[k-1];
        fwd_data[k] <= fwd_data[k-1];
      end
    end
  end

  assign parity_word = fwd_hit[mrpw_pkg::SRAM_DELAY-1] ? fwd_data[mrpw_pkg::SRAM_DELAY-1]
                                                       : parity_rdata;

  always_comb begin
    parity_cmd = '0;
    if (drain_slot) begin
      parity_cmd.write = pop;
      parity_cmd.row   = pq_row[0];
      parity_cmd.data  = pq_data[0];
    end else begin
      parity_cmd.read = conflict_rd.valid;
      parity_cmd.row  = conflict_rd.row;
    end
  end

endmodule

`default_nettype wire

//--- src/read_assembler.sv
`default_nettype none

module read_assembler (
  input  mrpw_pkg::rd_pipe_t rd_pipe [mrpw_pkg::NUM_RD_PORTS],
  input  mrpw_pkg::data_t    bank_rdata [mrpw_pkg::NUM_BANKS],
  input  mrpw_pkg::data_t    parity_word,
  output mrpw_pkg::rd_rsp_t  rd_rsp [mrpw_pkg::NUM_RD_PORTS]
);

  mrpw_pkg::data_t rebuilt;

  // the other banks plus parity give back the word of the busy bank
  always_comb begin
    rebuilt = parity_word;
    for (int b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin
      if (mrpw_pkg::BANK_W'(b) != rd_pipe[1].req.bank) begin
        rebuilt = rebuilt ^ bank_rdata[b];
      end
    end
  end

  always_comb begin
    for (int p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin
      rd_rsp[p].valid = rd_pipe[p].req.valid;
      if (p == 1 && rd_pipe[p].rebuild) begin
        rd_rsp[p].data = rebuilt;
      end else begin
        rd_rsp[p].data = bank_rdata[rd_pipe[p].req.bank];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/two_read_mem.sv
`default_nettype none

module two_read_mem (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                vwrite,
  input  logic [mrpw_pkg::ADDR_W-1:0]         vwraddr,
  input  mrpw_pkg::data_t                     vdin,
  input  logic [mrpw_pkg::NUM_RD_PORTS-1:0]   vread,
  input  logic [mrpw_pkg::ADDR_W-1:0]         vrdaddr [mrpw_pkg::NUM_RD_PORTS],
  output logic                                ready,
  output mrpw_pkg::rd_rsp_t                   rd_rsp [mrpw_pkg::NUM_RD_PORTS],
  output mrpw_pkg::bank_cmd_t                 bank_cmd [mrpw_pkg::NUM_BANKS],
  output mrpw_pkg::bank_cmd_t                 parity_cmd,
  input  mrpw_pkg::data_t                     bank_rdata [mrpw_pkg::NUM_BANKS],
  input  mrpw_pkg::data_t                     parity_rdata
);

  logic                       init_active;
  logic [mrpw_pkg::ROW_W-1:0] init_row;
  mrpw_pkg::rd_req_t          rd_req [mrpw_pkg::NUM_RD_PORTS];
  mrpw_pkg::wr_req_t          wr_req;
  mrpw_pkg::rd_req_t          conflict_rd;
  mrpw_pkg::rd_pipe_t         rd_pipe [mrpw_pkg::NUM_RD_PORTS];
  mrpw_pkg::data_t            parity_word;

  always_comb begin
    for (int p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin
      rd_req[p].valid = vread[p];
      rd_req[p].bank  = vrdaddr[p][mrpw_pkg::BANK_W-1:0];
      rd_req[p].row   = vrdaddr[p][mrpw_pkg::ADDR_W-1:mrpw_pkg::BANK_W];
    end
    wr_req.valid = vwrite;
    wr_req.bank  = vwraddr[mrpw_pkg::BANK_W-1:0];
    wr_req.row   = vwraddr[mrpw_pkg::ADDR_W-1:mrpw_pkg::BANK_W];
    wr_req.data  = vdin;
  end

  init_sequencer i_init (
    .clk         (clk),
    .rst         (rst),
    .init_active (init_active),
    .init_row    (init_row),
    .ready       (ready)
  );

  bank_scheduler i_sched (
    .clk         (clk),
    .rst         (rst),
    .ready       (ready),
    .init_active (init_active),
    .init_row    (init_row),
    .rd_req      (rd_req),
    .wr_req      (wr_req),
    .bank_cmd    (bank_cmd),
    .conflict_rd (conflict_rd),
    .rd_pipe     (rd_pipe)
  );

  parity_updater i_parity (
    .clk          (clk),
    .rst          (rst),
    .ready        (ready),
    .init_active  (init_active),
    .init_row     (init_row),
    .wr_req       (wr_req),
    .conflict_rd  (conflict_rd),
    .bank_rdata   (bank_rdata),
    .parity_rdata (parity_rdata),
    .parity_cmd   (parity_cmd),
    .parity_word  (parity_word)
  );

  read_assembler i_assemble (
    .rd_pipe     (rd_pipe),
    .bank_rdata  (bank_rdata),
    .parity_word (parity_word),
    .rd_rsp      (rd_rsp)
  );

endmodule

`default_nettype wire

//--- test/sram_model.sv
`default_nettype none

module sram_model (
  input  logic                clk,
  input  mrpw_pkg::bank_cmd_t cmd,
  output mrpw_pkg::data_t     rdata
);

  mrpw_pkg::data_t mem [mrpw_pkg::NUM_ROWS];
  mrpw_pkg::data_t rd_dly [mrpw_pkg::SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (cmd.write) begin
      mem[cmd.row] <= cmd.data;
    end
    if (cmd.read) begin
      rd_dly[0] <= mem[cmd.row]; // word as stored at the command edge
    end
    for (int k = 1; k < mrpw_pkg::SRAM_DELAY; k++) begin
      rd_dly[k] <= rd_dly[k-1];
    end
  end

  assign rdata = rd_dly[mrpw_pkg::SRAM_DELAY-1];

endmodule

`default_nettype wire

//--- test/tb_two_read_mem.sv
`default_nettype none

module tb_two_read_mem;

  localparam int RST_CYCLES  = 10;
  localparam int N_SINGLE    = 16;
  localparam int N_PAIRS     = 16;
  localparam int N_FWD       = 8;
  localparam int N_RANDOM    = 400;
  // a forwarding case takes at most four cycles
  localparam int TEST_CYCLES = 8 + 2 * N_SINGLE + N_PAIRS + 4 * N_FWD + N_RANDOM;
  localparam int CYCLE_LIMIT = RST_CYCLES + mrpw_pkg::NUM_ROWS + TEST_CYCLES + 64;

  logic                              clk;
  logic                              rst;
  logic                              vwrite;
  logic [mrpw_pkg::ADDR_W-1:0]       vwraddr;
  mrpw_pkg::data_t                   vdin;
  logic [mrpw_pkg::NUM_RD_PORTS-1:0] vread;
  logic [mrpw_pkg::ADDR_W-1:0]       vrdaddr [mrpw_pkg::NUM_RD_PORTS];
  logic                              ready;
  mrpw_pkg::rd_rsp_t                 rd_rsp [mrpw_pkg::NUM_RD_PORTS];
  mrpw_pkg::bank_cmd_t               bank_cmd [mrpw_pkg::NUM_BANKS];
  mrpw_pkg::bank_cmd_t               parity_cmd;
  mrpw_pkg::data_t                   bank_rdata [mrpw_pkg::NUM_BANKS];
  mrpw_pkg::data_t                   parity_rdata;

  mrpw_pkg::data_t shadow [mrpw_pkg::NUM_BANKS][mrpw_pkg::NUM_ROWS];
  mrpw_pkg::data_t exp_q [mrpw_pkg::NUM_RD_PORTS][$]; // expected words in issue order
  string           test_name;
  int              error_cnt = 0;
  int              check_cnt = 0;
  int              cycle_cnt = 0;
  integer          seed = 32'h8c15_765c;

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  two_read_mem i_dut (
    .clk          (clk),
    .rst          (rst),
    .vwrite       (vwrite),
    .vwraddr      (vwraddr),
    .vdin         (vdin),
    .vread        (vread),
    .vrdaddr      (vrdaddr),
    .ready        (ready),
    .rd_rsp       (rd_rsp),
    .bank_cmd     (bank_cmd),
    .parity_cmd   (parity_cmd),
    .bank_rdata   (bank_rdata),
    .parity_rdata (parity_rdata)
  );

  for (genvar b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin : g_bank
    sram_model i_bank (
      .clk   (clk),
      .cmd   (bank_cmd[b]),
      .rdata (bank_rdata[b])
    );
  end

  sram_model i_parity_bank (
    .clk   (clk),
    .cmd   (parity_cmd),
    .rdata (parity_rdata)
  );

  bind two_read_mem two_read_mem_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .vwrite     (vwrite),
    .vread      (vread),
    .ready      (ready),
    .rd_rsp     (rd_rsp),
    .bank_cmd   (bank_cmd),
    .parity_cmd (parity_cmd)
  );

  function automatic logic [mrpw_pkg::ADDR_W-1:0] make_addr(input int bank, input int row);
    return {mrpw_pkg::ROW_W'(row), mrpw_pkg::BANK_W'(bank)}; // bank sits in the low bits
  endfunction

  function automatic mrpw_pkg::data_t expected_word(input logic [mrpw_pkg::ADDR_W-1:0] addr);
    return shadow[addr[mrpw_pkg::BANK_W-1:0]][addr[mrpw_pkg::ADDR_W-1:mrpw_pkg::BANK_W]];
  endfunction

  task automatic check_rsp(input int port, input mrpw_pkg::data_t exp_data,
                           input mrpw_pkg::rd_rsp_t act);
    check_cnt++;
    if (act.data !== exp_data) begin
      error_cnt++;
      $display("[FAIL] %s port %0d: expected %h, actual %h", test_name, port, exp_data,
               act.data);
    end
  endtask

  task automatic check_cmd_idle(input string what, input mrpw_pkg::bank_cmd_t act);
    mrpw_pkg::bank_cmd_t idle_cmd = '0;
    check_cnt++;
    if (act !== idle_cmd) begin
      error_cnt++;
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, idle_cmd, act);
    end
  endtask

  task automatic drive_cycle(input logic wr, input logic [mrpw_pkg::ADDR_W-1:0] wr_addr,
                             input mrpw_pkg::data_t wr_data,
                             input logic [mrpw_pkg::NUM_RD_PORTS-1:0] rd,
                             input logic [mrpw_pkg::ADDR_W-1:0] rd_addr0,
                             input logic [mrpw_pkg::ADDR_W-1:0] rd_addr1);
    @(posedge clk);
    vwrite     <= wr;
    vwraddr    <= wr_addr;
    vdin       <= wr_data;
    vread      <= rd;
    vrdaddr[0] <= rd_addr0;
    vrdaddr[1] <= rd_addr1;
    if (wr) begin
      shadow[wr_addr[mrpw_pkg::BANK_W-1:0]][wr_addr[mrpw_pkg::ADDR_W-1:mrpw_pkg::BANK_W]] =
        wr_data;
    end
    if (rd[0]) begin
      exp_q[0].push_back(expected_word(rd_addr0));
    end
    if (rd[1]) begin
      exp_q[1].push_back(expected_word(rd_addr1));
    end
  endtask

  task automatic write_word(input logic [mrpw_pkg::ADDR_W-1:0] addr, input mrpw_pkg::data_t data);
    drive_cycle(1'b1, addr, data, '0, '0, '0);
  endtask

  task automatic read_ports(input logic [mrpw_pkg::NUM_RD_PORTS-1:0] rd,
                            input logic [mrpw_pkg::ADDR_W-1:0] addr0,
                            input logic [mrpw_pkg::ADDR_W-1:0] addr1);
    drive_cycle(1'b0, '0, '0, rd, addr0, addr1);
  endtask

  task automatic run_init_zero();
    test_name = "init_zero";
    while (!ready) begin
      @(posedge clk);
    end
    @(negedge clk);
    for (int b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin
      check_cmd_idle($sformatf("bank %0d command", b), bank_cmd[b]);
    end
    check_cmd_idle("parity command", parity_cmd);
    read_ports(2'b11, make_addr(0, 0), make_addr(5, 63));
    read_ports(2'b11, make_addr(3, 10), make_addr(3, 20)); // rebuilt from zero parity
    read_ports(2'b01, make_addr(7, 1), '0);
    read_ports(2'b10, '0, make_addr(2, 33));
  endtask

  task automatic run_single_rw();
    test_name = "single_rw";
    for (int i = 0; i < N_SINGLE; i++) begin
      write_word(make_addr(i % mrpw_pkg::NUM_BANKS, (i * 5) % mrpw_pkg::NUM_ROWS),
                 mrpw_pkg::DATA_W'($random(seed)));
    end
    for (int i = 0; i < N_SINGLE; i++) begin
      if (i % 2 == 0) begin
        read_ports(2'b01, make_addr(i % mrpw_pkg::NUM_BANKS, (i * 5) % mrpw_pkg::NUM_ROWS), '0);
      end else begin
        read_ports(2'b10, '0, make_addr(i % mrpw_pkg::NUM_BANKS, (i * 5) % mrpw_pkg::NUM_ROWS));
      end
    end
  endtask

  task automatic run_same_bank_pairs();
    int bank;
    int row_a;
    int row_b;
    test_name = "same_bank_pairs";
    for (int i = 0; i < N_PAIRS; i++) begin
      bank  = i % mrpw_pkg::NUM_BANKS;
      row_a = (bank * 5) % mrpw_pkg::NUM_ROWS;
      row_b = ((bank + 8) * 5) % mrpw_pkg::NUM_ROWS;
      if (i < mrpw_pkg::NUM_BANKS) begin
        read_ports(2'b11, make_addr(bank, row_a), make_addr(bank, row_b));
      end else begin
        read_ports(2'b11, make_addr(bank, row_b), make_addr(bank, row_a));
      end
    end
  endtask

  // writes to one row, then at once a conflicting pair whose port 1 hits that row
  task automatic run_parity_forward();
    int row;
    test_name = "parity_forward";
    for (int k = 0; k < N_FWD; k++) begin
      row = 32 + k;
      for (int j = 0; j <= k % 3; j++) begin
        write_word(make_addr((k + j % 2) % mrpw_pkg::NUM_BANKS, row),
                   mrpw_pkg::DATA_W'($random(seed)));
      end
      read_ports(2'b11, make_addr(k, row + 8), make_addr(k, row));
    end
  endtask

  task automatic run_random_mix();
    int r;
    int bank0;
    int bank1;
    test_name = "random_mix";
    for (int i = 0; i < N_RANDOM; i++) begin
      r     = $random(seed);
      bank0 = $random(seed) & (mrpw_pkg::NUM_BANKS - 1);
      bank1 = (r[2:1] == 2'b00) ? bank0 : ($random(seed) & (mrpw_pkg::NUM_BANKS - 1));
      if (r[0]) begin
        write_word(make_addr(bank0, $random(seed) & 7), mrpw_pkg::DATA_W'($random(seed)));
      end else begin
        read_ports(2'b11, make_addr(bank0, $random(seed) & 7), make_addr(bank1, r[5:3]));
      end
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      for (int p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin
        if (rd_rsp[p].valid) begin
          if (exp_q[p].size() == 0) begin
            error_cnt++;
            $display("unexpected response on port %0d in %s", p, test_name);
          end else begin
            check_rsp(p, exp_q[p].pop_front(), rd_rsp[p]);
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("timeout after %0d cycles in %s, %0d reads never answered", cycle_cnt,
               test_name, exp_q[0].size() + exp_q[1].size());
      $display("checks: %0d, errors: %0d", check_cnt, error_cnt + 1);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    rst        = 1'b1;
    vwrite     = 1'b0;
    vwraddr    = '0;
    vdin       = '0;
    vread      = '0;
    vrdaddr[0] = '0;
    vrdaddr[1] = '0;
    test_name  = "reset";
    for (int b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin
      for (int r = 0; r < mrpw_pkg::NUM_ROWS; r++) begin
        shadow[b][r] = '0;
      end
    end
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    run_init_zero();
    run_single_rw();
    run_same_bank_pairs();
    run_parity_forward();
    run_random_mix();
    read_ports('0, '0, '0);
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/two_read_mem_checker.sv
`default_nettype none

module two_read_mem_checker (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              vwrite,
  input  logic [mrpw_pkg::NUM_RD_PORTS-1:0] vread,
  input  logic                              ready,
  input  mrpw_pkg::rd_rsp_t                 rd_rsp [mrpw_pkg::NUM_RD_PORTS],
  input  mrpw_pkg::bank_cmd_t               bank_cmd [mrpw_pkg::NUM_BANKS],
  input  mrpw_pkg::bank_cmd_t               parity_cmd
);

  logic [mrpw_pkg::NUM_RD_PORTS-1:0] issued;
  logic                              cmd_any;

  assign issued = vread & {mrpw_pkg::NUM_RD_PORTS{ready && !vwrite}};

  always_comb begin
    cmd_any = parity_cmd.write || parity_cmd.read;
    for (int b = 0; b < mrpw_pkg::NUM_BANKS; b++) begin
      cmd_any = cmd_any || bank_cmd[b].write || bank_cmd[b].read;
    end
  end

  no_rd_with_wr: assert property (@(posedge clk) disable iff (rst) !(vwrite && vread != '0))
    else $error("read and write issued in the same cycle");

  // the first edge of reset still sees the power-up state
  no_cmd_in_rst: assert property (@(posedge clk) (rst && $past(rst)) |-> !cmd_any)
    else $error("bank command active during reset");

  for (genvar p = 0; p < mrpw_pkg::NUM_RD_PORTS; p++) begin : g_port
    rsp_latency: assert property (@(posedge clk) disable iff (rst)
      rd_rsp[p].valid == $past(issued[p], mrpw_pkg::SRAM_DELAY))
      else $error("port %0d response valid does not follow its read", p);
  end

endmodule

`default_nettype wire
